//--- sources.f
+incdir+include
hw/core_pkg.sv
hw/inst_queue.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/commit_stage.sv
hw/core_top.sv
verif/core_top_chk.sv
verif/core_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_top_tb
RTL_TOP   ?= core_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^SIMULATION PASSED$$" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/core_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module core_top_tb;
    import core_pkg::*;

    localparam int TAB_SIZE   = 128;
    localparam int WAIT_LIMIT = 200;

    logic  clk;
    logic  rst_n_i;
    logic  break_point_i;
    logic  inst_valid_i;
    word_t inst_i;
    word_t pc_i;
    logic  inst_ready_o;
    logic  ws_valid_o;
    word_t debug0_wb_pc_o;
    logic  debug0_wb_rf_wen_o;
    areg_t debug0_wb_rf_wnum_o;
    word_t debug0_wb_rf_wdata_o;

    // stimulus and expected commit, one row per instruction
    word_t tab_inst [TAB_SIZE];
    word_t tab_pc   [TAB_SIZE];
    logic  tab_wen  [TAB_SIZE];
    areg_t tab_rd   [TAB_SIZE];
    word_t tab_data [TAB_SIZE];
    int    tab_len;
    word_t next_pc;
    word_t model_rf [`CORE_NREG]; // reference register state

    int commit_idx;
    int err_cnt;
    int check_cnt;
    int tests_run;
    int tests_failed;

    core_top i_dut (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .break_point_i       (break_point_i),
        .inst_valid_i        (inst_valid_i),
        .inst_i              (inst_i),
        .pc_i                (pc_i),
        .inst_ready_o        (inst_ready_o),
        .ws_valid_o          (ws_valid_o),
        .debug0_wb_pc_o      (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o  (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o(debug0_wb_rf_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // LoongArch 3R encodings with the register fields cleared
    function automatic word_t op_base(input alu_op_e op);
        case (op)
            ALU_ADD:  return 32'h0010_0000;
            ALU_SUB:  return 32'h0011_0000;
            ALU_SLT:  return 32'h0012_0000;
            ALU_SLTU: return 32'h0012_8000;
            ALU_AND:  return 32'h0014_8000;
            ALU_OR:   return 32'h0015_0000;
            default:  return 32'h0015_8000;
        endcase
    endfunction

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            default:  return a ^ b;
        endcase
    endfunction

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_entry(input word_t inst, input logic wen, input areg_t rd,
                             input word_t data);
        tab_inst[tab_len] = inst;
        tab_pc[tab_len]   = next_pc;
        tab_wen[tab_len]  = wen;
        tab_rd[tab_len]   = rd;
        tab_data[tab_len] = data;
        tab_len++;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic emit_addi(input areg_t rd, input areg_t rj, input logic [11:0] imm);
        word_t res;
        res = model_rf[rj] + {{20{imm[11]}}, imm}; // si12
        add_entry({10'h00a, imm, rj, rd}, rd != '0, rd, res);
        if (rd != '0) begin
            model_rf[rd] = res;
        end
    endtask

    task automatic emit_3r(input alu_op_e op, input areg_t rd, input areg_t rj, input areg_t rk);
        word_t res;
        res = alu_model(op, model_rf[rj], model_rf[rk]);
        add_entry(op_base(op) | {17'b0, rk, rj, rd}, rd != '0, rd, res);
        if (rd != '0) begin
            model_rf[rd] = res;
        end
    endtask

    task automatic emit_unknown(input word_t word);
        add_entry(word, 1'b0, word[4:0], '0); // retires, writes nothing
    endtask

    // returns just after the edge that took the word
    task automatic wait_accept();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!inst_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!inst_ready_o) begin
            err_cnt++;
            $display("Timeout: inst_ready_o stayed low, word at pc %h was not accepted", pc_i);
        end
        @(posedge clk);
    endtask

    task automatic drive_range(input int lo, input int max_gap);
        int gap;
        for (int i = lo; i < tab_len; i++) begin
            gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
            repeat (gap) begin
                inst_valid_i <= 1'b0;
                @(posedge clk);
            end
            inst_valid_i <= 1'b1;
            inst_i       <= tab_inst[i];
            pc_i         <= tab_pc[i];
            wait_accept();
        end
        inst_valid_i <= 1'b0;
    endtask

    task automatic wait_commits(input int target);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (commit_idx < target && waited < WAIT_LIMIT);
        if (commit_idx < target) begin
            err_cnt++;
            $display("Timeout: only %0d of %0d instructions committed", commit_idx, target);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (err_cnt == errs_before) ? "ok" : "mismatch");
    endtask

    // commit outputs settle after the rising edge
    always @(negedge clk) begin
        if (rst_n_i && ws_valid_o) begin
            if (commit_idx >= tab_len) begin
                err_cnt++;
                $display("Unexpected commit at %0t ns, pc %h is past the last instruction",
                         $time, debug0_wb_pc_o);
            end else begin
                check_value("commit pc", debug0_wb_pc_o, tab_pc[commit_idx]);
                check_value("write enable", word_t'(debug0_wb_rf_wen_o),
                            word_t'(tab_wen[commit_idx]));
                if (tab_wen[commit_idx]) begin
                    check_value("write number", word_t'(debug0_wb_rf_wnum_o),
                                word_t'(tab_rd[commit_idx]));
                    check_value("write data", debug0_wb_rf_wdata_o, tab_data[commit_idx]);
                end
                commit_idx++;
            end
        end
    end

    initial begin
        int lo;
        int errs;
        int pick;
        int total_err;
        void'($urandom(68));
        rst_n_i       = 1'b0;
        break_point_i = 1'b0;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        pc_i          = '0;
        tab_len       = 0;
        next_pc       = 32'h1c00_0000;
        commit_idx    = 0;
        err_cnt       = 0;
        check_cnt     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int r = 0; r < `CORE_NREG; r++) begin
            model_rf[r] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);

        errs = err_cnt;
        @(negedge clk);
        check_value("ws_valid_o after reset", word_t'(ws_valid_o), 32'd0);
        check_value("wb_rf_wen after reset", word_t'(debug0_wb_rf_wen_o), 32'd0);
        check_value("inst_ready_o after reset", word_t'(inst_ready_o), 32'd1);
        end_test("reset state", errs);
        @(posedge clk);

        errs = err_cnt;
        lo   = tab_len;
        emit_addi(5'd1, 5'd0, 12'h001);
        emit_addi(5'd2, 5'd0, 12'h7ff);
        emit_addi(5'd3, 5'd0, 12'h800); // most negative si12
        emit_addi(5'd4, 5'd3, 12'hfff);
        emit_addi(5'd5, 5'd2, 12'h001);
        emit_addi(5'd1, 5'd1, 12'h00f);
        drive_range(lo, 0);
        wait_commits(tab_len);
        end_test("addi constants", errs);

        errs = err_cnt;
        lo   = tab_len;
        for (int k = 0; k < 7; k++) begin
            emit_addi(5'd5, 5'd0, 12'($urandom));
            emit_addi(5'd6, 5'd0, 12'($urandom));
            emit_3r(alu_op_e'(3'(k)), 5'd7, 5'd5, 5'd6);
            emit_3r(alu_op_e'(3'(k)), 5'd8, 5'd7, 5'd6); // reads r7 right after its commit
        end
        drive_range(lo, 0);
        wait_commits(tab_len);
        end_test("3R operations", errs);

        errs = err_cnt;
        lo   = tab_len;
        emit_addi(5'd0, 5'd0, 12'h123);
        emit_3r(ALU_ADD, 5'd0, 5'd5, 5'd6);
        emit_unknown(32'hffff_ffff);
        emit_unknown(32'h0000_0000);
        emit_3r(ALU_OR, 5'd9, 5'd0, 5'd0);
        emit_addi(5'd10, 5'd0, 12'h001);
        drive_range(lo, 0);
        wait_commits(tab_len);
        end_test("r0 and unknown words", errs);

        errs = err_cnt;
        lo   = tab_len;
        for (int k = 0; k < `CORE_QUEUE_DEPTH; k++) begin
            emit_addi(areg_t'(12 + k), areg_t'(11 + k), 12'(k + 1));
        end
        break_point_i <= 1'b1;
        drive_range(lo, 0);
        @(negedge clk);
        check_value("inst_ready_o with full queue", word_t'(inst_ready_o), 32'd0);
        // one more word waits at the full queue
        emit_addi(areg_t'(12 + `CORE_QUEUE_DEPTH), areg_t'(11 + `CORE_QUEUE_DEPTH),
                  12'(`CORE_QUEUE_DEPTH + 1));
        @(posedge clk);
        fork
            drive_range(lo + `CORE_QUEUE_DEPTH, 0);
            begin
                repeat (4) @(posedge clk);
                check_value("commits while held", word_t'(commit_idx - lo), 32'd0);
                break_point_i <= 1'b0;
            end
        join
        wait_commits(tab_len);
        end_test("break point hold", errs);

        errs = err_cnt;
        lo   = tab_len;
        for (int k = 0; k < 40; k++) begin
            pick = $urandom_range(9, 0);
            if (pick < 3) begin
                emit_addi(areg_t'($urandom_range(7, 0)), areg_t'($urandom_range(7, 0)),
                          12'($urandom));
            end else begin
                emit_3r(alu_op_e'(3'($urandom_range(6, 0))), areg_t'($urandom_range(7, 0)),
                        areg_t'($urandom_range(7, 0)), areg_t'($urandom_range(7, 0)));
            end
        end
        drive_range(lo, 3);
        wait_commits(tab_len);
        repeat (3) @(posedge clk); // catch any extra commit
        end_test("random gaps", errs);

        total_err = err_cnt + i_dut.i_chk.fail_count;
        $display("tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_cnt, err_cnt, i_dut.i_chk.fail_count);
        if (total_err == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/core_top_chk.sv
`timescale 1ns/100ps
`default_nettype none

module core_top_chk (
    input wire                  clk,
    input wire                  rst_n_i,
    input wire                  inst_valid_i,
    input wire core_pkg::word_t inst_i,
    input wire core_pkg::word_t pc_i,
    input wire                  inst_ready_i,
    input wire                  ws_valid_i,
    input wire                  wb_rf_wen_i,
    input wire core_pkg::areg_t wb_rf_wnum_i
);

    int fail_count = 0; // read by the testbench at the end of the run

    wen_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_rf_wen_i |-> ws_valid_i)
        else begin
            fail_count++;
            $error("register write reported without ws_valid");
        end

    // r0 is never a write target
    wnum_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_rf_wen_i |-> (wb_rf_wnum_i != '0))
        else begin
            fail_count++;
            $error("register write to r0 reported");
        end

    src_holds_word: assert property (@(posedge clk) disable iff (!rst_n_i)
        (inst_valid_i && !inst_ready_i) |=> ($stable(inst_i) && $stable(pc_i)))
        else begin
            fail_count++;
            $error("inst or pc changed while waiting for ready");
        end

    no_commit_in_reset: assert property (@(posedge clk) !rst_n_i |-> !ws_valid_i)
        else begin
            fail_count++;
            $error("ws_valid high during reset");
        end

endmodule

bind core_top core_top_chk i_chk (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .inst_valid_i(inst_valid_i),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .inst_ready_i(inst_ready_o),
    .ws_valid_i  (ws_valid_o),
    .wb_rf_wen_i (debug0_wb_rf_wen_o),
    .wb_rf_wnum_i(debug0_wb_rf_wnum_o)
);

`default_nettype wire

//--- hw/core_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module core_top (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  break_point_i,
    input  wire                  inst_valid_i,
    input  wire core_pkg::word_t inst_i,
    input  wire core_pkg::word_t pc_i,
    output logic                 inst_ready_o,
    output logic                 ws_valid_o,
    output core_pkg::word_t      debug0_wb_pc_o,
    output logic                 debug0_wb_rf_wen_o,
    output core_pkg::areg_t      debug0_wb_rf_wnum_o,
    output core_pkg::word_t      debug0_wb_rf_wdata_o
);

    // queue to decode
    logic              q_valid;
    core_pkg::word_t   q_inst;
    core_pkg::word_t   q_pc;

    // decode to execute
    logic              d_valid;
    core_pkg::word_t   d_pc;
    core_pkg::alu_op_e d_op;
    core_pkg::areg_t   d_rj;
    core_pkg::areg_t   d_rk;
    logic              d_use_imm;
    core_pkg::word_t   d_imm;
    logic              d_wen;
    core_pkg::areg_t   d_rd;

    // execute to commit
    logic              e_valid;
    core_pkg::word_t   e_pc;
    logic              e_wen;
    core_pkg::areg_t   e_rd;
    core_pkg::word_t   e_result;

    // register file reads
    core_pkg::areg_t   rj;
    core_pkg::areg_t   rk;
    core_pkg::word_t   rdata_j;
    core_pkg::word_t   rdata_k;

    // no bypass, the queue is decode's input register
    inst_queue #(
        .DEPTH(`CORE_QUEUE_DEPTH)
    ) i_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .break_point_i(break_point_i),
        .in_valid_i   (inst_valid_i),
        .in_inst_i    (inst_i),
        .in_pc_i      (pc_i),
        .in_ready_o   (inst_ready_o),
        .out_valid_o  (q_valid),
        .out_inst_o   (q_inst),
        .out_pc_o     (q_pc)
    );

    decode_stage i_decode_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_valid_i(q_valid),
        .inst_i      (q_inst),
        .pc_i        (q_pc),
        .d_valid_o   (d_valid),
        .d_pc_o      (d_pc),
        .d_op_o      (d_op),
        .d_rj_o      (d_rj),
        .d_rk_o      (d_rk),
        .d_use_imm_o (d_use_imm),
        .d_imm_o     (d_imm),
        .d_wen_o     (d_wen),
        .d_rd_o      (d_rd)
    );

    execute_stage i_execute_stage (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .d_valid_i  (d_valid),
        .d_pc_i     (d_pc),
        .d_op_i     (d_op),
        .d_rj_i     (d_rj),
        .d_rk_i     (d_rk),
        .d_use_imm_i(d_use_imm),
        .d_imm_i    (d_imm),
        .d_wen_i    (d_wen),
        .d_rd_i     (d_rd),
        .rj_o       (rj),
        .rk_o       (rk),
        .rdata_j_i  (rdata_j),
        .rdata_k_i  (rdata_k),
        .e_valid_o  (e_valid),
        .e_pc_o     (e_pc),
        .e_wen_o    (e_wen),
        .e_rd_o     (e_rd),
        .e_result_o (e_result)
    );

    commit_stage i_commit_stage (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .e_valid_i           (e_valid),
        .e_pc_i              (e_pc),
        .e_wen_i             (e_wen),
        .e_rd_i              (e_rd),
        .e_result_i          (e_result),
        .rj_i                (rj),
        .rk_i                (rk),
        .rdata_j_o           (rdata_j),
        .rdata_k_o           (rdata_k),
        .ws_valid_o          (ws_valid_o),
        .debug0_wb_pc_o      (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o  (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o(debug0_wb_rf_wdata_o)
    );

endmodule

`default_nettype wire

//--- hw/commit_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module commit_stage (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  e_valid_i,
    input  wire core_pkg::word_t e_pc_i,
    input  wire                  e_wen_i,
    input  wire core_pkg::areg_t e_rd_i,
    input  wire core_pkg::word_t e_result_i,
    input  wire core_pkg::areg_t rj_i,
    input  wire core_pkg::areg_t rk_i,
    output core_pkg::word_t      rdata_j_o,
    output core_pkg::word_t      rdata_k_o,
    output logic                 ws_valid_o,
    output core_pkg::word_t      debug0_wb_pc_o,
    output logic                 debug0_wb_rf_wen_o,
    output core_pkg::areg_t      debug0_wb_rf_wnum_o,
    output core_pkg::word_t      debug0_wb_rf_wdata_o
);
    import core_pkg::*;

    word_t rf [`CORE_NREG];
    logic  wr_en;

    assign wr_en = e_wen_i; // execute gates it with valid, decode clears it for r0

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_NREG; i++) begin
                rf[i] <= '0;
            end
        end else if (wr_en) begin
            rf[e_rd_i] <= e_result_i;
        end
    end

    // write-first, so a reader in execute sees the value retiring now
    function automatic word_t read_port(input areg_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en && (idx == e_rd_i)) begin
            val = e_result_i;
        end else begin
            val = rf[idx];
        end
        return val;
    endfunction

    always_comb begin
        rdata_j_o = read_port(rj_i);
        rdata_k_o = read_port(rk_i);
    end

    // trace of the retiring instruction
    assign ws_valid_o           = e_valid_i;
    assign debug0_wb_pc_o       = e_pc_i;
    assign debug0_wb_rf_wen_o   = wr_en;
    assign debug0_wb_rf_wnum_o  = e_rd_i;
    assign debug0_wb_rf_wdata_o = e_result_i;

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module execute_stage (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    d_valid_i,
    input  wire core_pkg::word_t   d_pc_i,
    input  wire core_pkg::alu_op_e d_op_i,
    input  wire core_pkg::areg_t   d_rj_i,
    input  wire core_pkg::areg_t   d_rk_i,
    input  wire                    d_use_imm_i,
    input  wire core_pkg::word_t   d_imm_i,
    input  wire                    d_wen_i,
    input  wire core_pkg::areg_t   d_rd_i,
    output core_pkg::areg_t        rj_o,
    output core_pkg::areg_t        rk_o,
    input  wire core_pkg::word_t   rdata_j_i,
    input  wire core_pkg::word_t   rdata_k_i,
    output logic                   e_valid_o,
    output core_pkg::word_t        e_pc_o,
    output logic                   e_wen_o,
    output core_pkg::areg_t        e_rd_o,
    output core_pkg::word_t        e_result_o
);
    import core_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t alu_res;

    // operands come straight from the register file read ports
    assign rj_o  = d_rj_i;
    assign rk_o  = d_rk_i;
    assign src_a = rdata_j_i;
    assign src_b = d_use_imm_i ? d_imm_i : rdata_k_i;

    always_comb begin
        case (d_op_i)
            ALU_ADD:  alu_res = src_a + src_b; // wraps at 32 bits
            ALU_SUB:  alu_res = src_a - src_b;
            ALU_SLT:  alu_res = {{(`CORE_XLEN - 1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: alu_res = {{(`CORE_XLEN - 1){1'b0}}, src_a < src_b};
            ALU_AND:  alu_res = src_a & src_b;
            ALU_OR:   alu_res = src_a | src_b;
            ALU_XOR:  alu_res = src_a ^ src_b;
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            e_valid_o <= 1'b0;
            e_wen_o   <= 1'b0;
        end else begin
            e_valid_o <= d_valid_i;
            e_wen_o   <= d_valid_i && d_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        e_pc_o     <= d_pc_i;
        e_rd_o     <= d_rd_i;
        e_result_o <= alu_res;
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module decode_stage (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  inst_valid_i,
    input  wire core_pkg::word_t inst_i,
    input  wire core_pkg::word_t pc_i,
    output logic                 d_valid_o,
    output core_pkg::word_t      d_pc_o,
    output core_pkg::alu_op_e    d_op_o,
    output core_pkg::areg_t      d_rj_o,
    output core_pkg::areg_t      d_rk_o,
    output logic                 d_use_imm_o,
    output core_pkg::word_t      d_imm_o,
    output logic                 d_wen_o,
    output core_pkg::areg_t      d_rd_o
);
    import core_pkg::*;

    // 3R major opcodes, inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;
    // 2RI12 opcode, inst[31:22]
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;

    alu_op_e op;
    logic    use_imm;
    logic    known;
    word_t   imm;
    areg_t   rd;

    always_comb begin
        op      = ALU_ADD;
        use_imm = 1'b0;
        known   = 1'b1;
        if (inst_i[31:22] == OP_ADDI_W) begin
            use_imm = 1'b1; // addi.w runs as an add
        end else begin
            case (inst_i[31:15])
                OP_ADD_W: op = ALU_ADD;
                OP_SUB_W: op = ALU_SUB;
                OP_SLT:   op = ALU_SLT;
                OP_SLTU:  op = ALU_SLTU;
                OP_AND:   op = ALU_AND;
                OP_OR:    op = ALU_OR;
                OP_XOR:   op = ALU_XOR;
                default:  known = 1'b0;
            endcase
        end
    end

    assign imm = {{(`CORE_XLEN - 12){inst_i[21]}}, inst_i[21:10]}; // si12
    assign rd  = inst_i[4:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            d_valid_o <= 1'b0;
            d_wen_o   <= 1'b0;
        end else begin
            d_valid_o <= inst_valid_i;
            // unknown words and r0 targets still retire, just without a write
            d_wen_o   <= inst_valid_i && known && (rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        d_pc_o      <= pc_i;
        d_op_o      <= op;
        d_rj_o      <= inst_i[9:5];
        d_rk_o      <= inst_i[14:10];
        d_use_imm_o <= use_imm;
        d_imm_o     <= imm;
        d_rd_o      <= rd;
    end

endmodule

`default_nettype wire

//--- hw/inst_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module inst_queue #(
    parameter int DEPTH = `CORE_QUEUE_DEPTH
) (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  break_point_i,
    input  wire                  in_valid_i,
    input  wire core_pkg::word_t in_inst_i,
    input  wire core_pkg::word_t in_pc_i,
    output logic                 in_ready_o,
    output logic                 out_valid_o,
    output core_pkg::word_t      out_inst_o,
    output core_pkg::word_t      out_pc_o
);
    import core_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t            inst_mem [DEPTH];
    word_t            pc_mem   [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    assign in_ready_o  = (count != CNT_W'(DEPTH));
    assign out_valid_o = (count != '0) && !break_point_i; // hold keeps entries in place
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o;                     // decode takes one per cycle

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // storage doubles as the decode input register
    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr] <= in_inst_i;
            pc_mem[wr_ptr]   <= in_pc_i;
        end
    end

    assign out_inst_o = inst_mem[rd_ptr];
    assign out_pc_o   = pc_mem[rd_ptr];

endmodule

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

`include "core_config.svh"

package core_pkg;

    // pc, instruction and data words share one width
    typedef logic [`CORE_XLEN-1:0] word_t;

    // architectural register number
    typedef logic [`CORE_AREG_W-1:0] areg_t;

    // operations the single ALU can perform
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_SLT  = 3'd2,
        ALU_SLTU = 3'd3,
        ALU_AND  = 3'd4,
        ALU_OR   = 3'd5,
        ALU_XOR  = 3'd6
    } alu_op_e;

endpackage

`default_nettype wire

//--- include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath and instruction word width
`define CORE_XLEN 32

// architectural register file
`define CORE_NREG 32
`define CORE_AREG_W 5

// entries in the queue ahead of decode
`define CORE_QUEUE_DEPTH 4

`endif
